/* hdl/cnn_num_pkg.sv */
package cnn_num_pkg;

	// ------------------------------------------------------------------------
	// sample and accumulator widths
	// ------------------------------------------------------------------------
	localparam int DATA_W = 16;
	// product is 2*DATA_W, plus guard bits for 27 terms
	localparam int ACC_W = 2 * DATA_W + 4;

	// ------------------------------------------------------------------------
	// array geometry
	// ------------------------------------------------------------------------
	localparam int IMG_SIZE  = 4;
	localparam int K_SIZE    = 3;
	localparam int N_CH      = 3;
	localparam int N_KERNELS = 4;
	localparam int OUT_SIZE  = 8;

	// leaky relu slope, floor(x / 8)
	localparam int LEAK_SHIFT = 3;

endpackage

/* hdl/cnn_mode_pkg.sv */
package cnn_mode_pkg;

	typedef enum logic {
		PAD_REPLICATE = 1'b0,
		PAD_ZERO      = 1'b1
	} pad_mode_e;

	typedef enum logic {
		ACT_RELU  = 1'b0,
		ACT_LEAKY = 1'b1
	} act_mode_e;

	// bit 1 pad, bit 0 activation
	typedef struct packed {
		pad_mode_e pad;
		act_mode_e act;
	} opt_t;

endpackage

/* hdl/operand_if.sv */
interface operand_if #(
	parameter int DATA_W = cnn_num_pkg::DATA_W
);
	// request from the engine
	logic [$clog2(cnn_num_pkg::N_KERNELS)-1:0] kidx;
	logic [$clog2(cnn_num_pkg::IMG_SIZE)-1:0]  oy;
	logic [$clog2(cnn_num_pkg::IMG_SIZE)-1:0]  ox;
	logic [$clog2(cnn_num_pkg::K_SIZE)-1:0]    krow;

	// one padded row and one kernel row per channel, same cycle
	logic signed [DATA_W-1:0] pix [cnn_num_pkg::N_CH][cnn_num_pkg::K_SIZE];
	logic signed [DATA_W-1:0] wgt [cnn_num_pkg::N_CH][cnn_num_pkg::K_SIZE];
	logic                     loaded;

	modport loader (input kidx, oy, ox, krow, output pix, wgt, loaded);
	modport engine (output kidx, oy, ox, krow, input pix, wgt, loaded);

endinterface

/* hdl/result_if.sv */
interface result_if #(
	parameter int ACC_W = cnn_num_pkg::ACC_W
);
	logic                                      valid;
	logic signed [ACC_W-1:0]                   data;
	logic [$clog2(cnn_num_pkg::N_KERNELS)-1:0] kidx;
	logic [$clog2(cnn_num_pkg::IMG_SIZE)-1:0]  oy;
	logic [$clog2(cnn_num_pkg::IMG_SIZE)-1:0]  ox;
	// end of output stream, clears the job
	logic                                      done;

	modport engine  (output valid, data, kidx, oy, ox, input done);
	modport shuffle (input valid, data, kidx, oy, ox, output done);

endinterface

/* hdl/input_loader.sv */
module input_loader #(
	parameter int DATA_W = cnn_num_pkg::DATA_W
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid_o,
	input  cnn_mode_pkg::opt_t       opt,
	input  logic                     in_valid_i,
	input  logic signed [DATA_W-1:0] image1,
	input  logic signed [DATA_W-1:0] image2,
	input  logic signed [DATA_W-1:0] image3,
	input  logic                     in_valid_k,
	input  logic signed [DATA_W-1:0] kernel1,
	input  logic signed [DATA_W-1:0] kernel2,
	input  logic signed [DATA_W-1:0] kernel3,
	operand_if.loader                op,
	input  logic                     done,
	output cnn_mode_pkg::act_mode_e  act
);
	localparam int NS = cnn_num_pkg::IMG_SIZE;
	localparam int KS = cnn_num_pkg::K_SIZE;
	localparam int NC = cnn_num_pkg::N_CH;
	localparam int NK = cnn_num_pkg::N_KERNELS;

	cnn_mode_pkg::opt_t       opt_q;
	logic signed [DATA_W-1:0] img [NC][NS][NS];
	logic signed [DATA_W-1:0] wgt_mem [NC][NK][KS*KS];
	logic [1:0]               row_cnt, col_cnt, kern_cnt;
	logic [3:0]               wgt_cnt;

	// padded coordinate 0..5 to image index, clamped at the edges
	function automatic logic [1:0] img_index(input logic [2:0] p);
		logic [1:0] idx;
		if (p == 3'd0)
			idx = 2'd0;
		else if (p > 3'(NS))
			idx = 2'(NS - 1);
		else
			idx = 2'(p - 3'd1);
		return idx;
	endfunction

	// ------------------------------------------------------------------------
	// option, image and kernel load
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			opt_q     <= '0;
			row_cnt   <= '0;
			col_cnt   <= '0;
			kern_cnt  <= '0;
			wgt_cnt   <= '0;
			op.loaded <= 1'b0;
		end
		else if (in_valid_o)
		begin
			opt_q    <= opt;
			row_cnt  <= '0;
			col_cnt  <= '0;
			kern_cnt <= '0;
			wgt_cnt  <= '0;
		end
		else if (in_valid_i)
		begin
			col_cnt <= col_cnt + 2'd1;
			if (col_cnt == 2'(NS - 1))
				row_cnt <= row_cnt + 2'd1;
		end
		else if (in_valid_k)
		begin
			wgt_cnt <= wgt_cnt + 4'd1;
			if (wgt_cnt == 4'(KS * KS - 1))
			begin
				wgt_cnt  <= '0;
				kern_cnt <= kern_cnt + 2'd1;
				// last weight of the last kernel
				if (kern_cnt == 2'(NK - 1))
					op.loaded <= 1'b1;
			end
		end
		else if (done)
			op.loaded <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (in_valid_i)
		begin
			img[0][row_cnt][col_cnt] <= image1;
			img[1][row_cnt][col_cnt] <= image2;
			img[2][row_cnt][col_cnt] <= image3;
		end
		if (in_valid_k)
		begin
			wgt_mem[0][kern_cnt][wgt_cnt] <= kernel1;
			wgt_mem[1][kern_cnt][wgt_cnt] <= kernel2;
			wgt_mem[2][kern_cnt][wgt_cnt] <= kernel3;
		end
	end

	// ------------------------------------------------------------------------
	// padded operand row, row oy+krow, columns ox..ox+2
	// ------------------------------------------------------------------------
	always_comb
	begin
		logic [2:0] pr;
		logic [2:0] pc;
		logic       border;
		pr = {1'b0, op.oy} + {1'b0, op.krow};
		for (int c = 0; c < NC; c++)
		begin
			for (int j = 0; j < KS; j++)
			begin
				pc = {1'b0, op.ox} + 3'(j);
				border = (pr == 3'd0) || (pr == 3'(NS + 1)) ||
					(pc == 3'd0) || (pc == 3'(NS + 1));
				if (border && opt_q.pad == cnn_mode_pkg::PAD_ZERO)
					op.pix[c][j] = '0;
				else
					op.pix[c][j] = img[c][img_index(pr)][img_index(pc)];
				op.wgt[c][j] = wgt_mem[c][op.kidx][int'(op.krow) * KS + j];
			end
		end
	end

	assign act = opt_q.act;

endmodule

/* hdl/conv_engine.sv */
module conv_engine #(
	parameter int DATA_W = cnn_num_pkg::DATA_W,
	parameter int ACC_W  = cnn_num_pkg::ACC_W
) (
	input  logic      clk,
	input  logic      rst_n,
	operand_if.engine op,
	result_if.engine  res
);
	localparam int KS = cnn_num_pkg::K_SIZE;
	localparam int NC = cnn_num_pkg::N_CH;

	logic [1:0] kidx, oy, ox, krow;
	logic       finished;
	logic       issue;
	logic       last_step;

	// stage 1, products
	logic signed [2*DATA_W-1:0] prod [NC][KS];
	logic                       s1_valid, s1_first, s1_last;
	logic [1:0]                 s1_kidx, s1_oy, s1_ox;
	// stage 2, channel and row sum
	logic signed [ACC_W-1:0]    row_sum_c;
	logic signed [ACC_W-1:0]    row_sum;
	logic                       s2_valid, s2_first, s2_last;
	logic [1:0]                 s2_kidx, s2_oy, s2_ox;
	logic signed [ACC_W-1:0]    acc;

	assign issue = op.loaded && !finished;
	assign last_step = (kidx == 2'd3) && (oy == 2'd3) && (ox == 2'd3) &&
		(krow == 2'(KS - 1));

	assign op.kidx = kidx;
	assign op.oy   = oy;
	assign op.ox   = ox;
	assign op.krow = krow;

	// ------------------------------------------------------------------------
	// sweep counters, krow fastest then ox, oy, kidx
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			{kidx, oy, ox, krow} <= '0;
			finished <= 1'b0;
		end
		else if (res.done)
		begin
			{kidx, oy, ox, krow} <= '0;
			finished <= 1'b0;
		end
		else if (issue)
		begin
			// the 8-bit counter chain wraps to zero after the last step
			if (krow == 2'(KS - 1))
			begin
				krow <= '0;
				{kidx, oy, ox} <= {kidx, oy, ox} + 6'd1;
			end
			else
				krow <= krow + 2'd1;
			if (last_step)
				finished <= 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// pipeline
	// ------------------------------------------------------------------------
	always_comb
	begin
		row_sum_c = '0;
		for (int c = 0; c < NC; c++)
			for (int j = 0; j < KS; j++)
				row_sum_c = row_sum_c + prod[c][j];
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			res.valid <= 1'b0;
		end
		else
		begin
			s1_valid  <= issue;
			s2_valid  <= s1_valid;
			res.valid <= s2_valid && s2_last;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int c = 0; c < NC; c++)
			for (int j = 0; j < KS; j++)
				prod[c][j] <= op.pix[c][j] * op.wgt[c][j];
		s1_first <= (krow == 2'd0);
		s1_last  <= (krow == 2'(KS - 1));
		{s1_kidx, s1_oy, s1_ox} <= {kidx, oy, ox};

		row_sum  <= row_sum_c;
		s2_first <= s1_first;
		s2_last  <= s1_last;
		{s2_kidx, s2_oy, s2_ox} <= {s1_kidx, s1_oy, s1_ox};

		// first two rows build up here, the third closes the result
		if (s2_valid)
			acc <= s2_first ? row_sum : acc + row_sum;
		if (s2_valid && s2_last)
		begin
			res.data <= acc + row_sum;
			res.kidx <= s2_kidx;
			res.oy   <= s2_oy;
			res.ox   <= s2_ox;
		end
	end

endmodule

/* hdl/output_shuffle.sv */
module output_shuffle #(
	parameter int ACC_W = cnn_num_pkg::ACC_W
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  cnn_mode_pkg::act_mode_e act,
	result_if.shuffle               res,
	output logic                    out_valid,
	output logic [ACC_W-1:0]        out
);
	localparam int NO = cnn_num_pkg::OUT_SIZE;
	localparam int N_PIX = NO * NO;

	typedef enum logic {
		ST_FILL,
		ST_STREAM
	} state_e;

	state_e                  state;
	logic signed [ACC_W-1:0] shuf_mem [NO][NO];
	logic signed [ACC_W-1:0] act_val;
	logic [6:0]              wr_cnt;
	logic [6:0]              rd_cnt;
	logic                    start;

	// ------------------------------------------------------------------------
	// activation
	// ------------------------------------------------------------------------
	always_comb
	begin
		act_val = res.data;
		if (res.data < 0)
		begin
			if (act == cnn_mode_pkg::ACT_LEAKY)
				act_val = res.data >>> cnn_num_pkg::LEAK_SHIFT;
			else
				act_val = '0;
		end
	end

	// kernel index picks the position inside each 2x2 block
	always_ff @(posedge clk)
	begin
		if (res.valid)
			shuf_mem[{res.oy, res.kidx[1]}][{res.ox, res.kidx[0]}] <= act_val;
	end

	// 64th write lands on this edge
	assign start = (state == ST_FILL) && res.valid && (wr_cnt == 7'(N_PIX - 1));

	// ------------------------------------------------------------------------
	// fill / stream control
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= ST_FILL;
			wr_cnt    <= '0;
			rd_cnt    <= '0;
			out_valid <= 1'b0;
			out       <= '0;
			res.done  <= 1'b0;
		end
		else
		begin
			res.done <= (state == ST_STREAM) && (rd_cnt == 7'(N_PIX - 1));
			case (state)
				ST_FILL:
				begin
					if (start)
					begin
						// slot 0,0 was written long before the last result
						state     <= ST_STREAM;
						wr_cnt    <= '0;
						out_valid <= 1'b1;
						out       <= shuf_mem[0][0];
						rd_cnt    <= 7'd1;
					end
					else if (res.valid)
						wr_cnt <= wr_cnt + 7'd1;
				end
				ST_STREAM:
				begin
					if (rd_cnt == 7'(N_PIX))
					begin
						state     <= ST_FILL;
						rd_cnt    <= '0;
						out_valid <= 1'b0;
						out       <= '0;
					end
					else
					begin
						out    <= shuf_mem[rd_cnt[5:3]][rd_cnt[2:0]];
						rd_cnt <= rd_cnt + 7'd1;
					end
				end
				default:
					state <= ST_FILL;
			endcase
		end
	end

endmodule

/* hdl/cnn_top.sv */
module cnn_top #(
	parameter int DATA_W = cnn_num_pkg::DATA_W,
	parameter int ACC_W  = cnn_num_pkg::ACC_W
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid_o,
	input  logic [1:0]        opt,
	input  logic              in_valid_i,
	input  logic [DATA_W-1:0] image1,
	input  logic [DATA_W-1:0] image2,
	input  logic [DATA_W-1:0] image3,
	input  logic              in_valid_k,
	input  logic [DATA_W-1:0] kernel1,
	input  logic [DATA_W-1:0] kernel2,
	input  logic [DATA_W-1:0] kernel3,
	output logic              out_valid,
	output logic [ACC_W-1:0]  out
);
	cnn_mode_pkg::act_mode_e act;

	operand_if #(.DATA_W(DATA_W)) op_bus ();
	result_if  #(.ACC_W(ACC_W))   res_bus ();

	input_loader #(.DATA_W(DATA_W)) loader_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_o (in_valid_o),
		.opt        (cnn_mode_pkg::opt_t'(opt)),
		.in_valid_i (in_valid_i),
		.image1     (image1),
		.image2     (image2),
		.image3     (image3),
		.in_valid_k (in_valid_k),
		.kernel1    (kernel1),
		.kernel2    (kernel2),
		.kernel3    (kernel3),
		.op         (op_bus.loader),
		.done       (res_bus.done),
		.act        (act)
	);

	conv_engine #(.DATA_W(DATA_W), .ACC_W(ACC_W)) engine_i (
		.clk   (clk),
		.rst_n (rst_n),
		.op    (op_bus.engine),
		.res   (res_bus.engine)
	);

	output_shuffle #(.ACC_W(ACC_W)) shuffle_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.act       (act),
		.res       (res_bus.shuffle),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule

/* testbench/cnn_tb.sv */
module cnn_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int DATA_W = cnn_num_pkg::DATA_W;
	localparam int ACC_W  = cnn_num_pkg::ACC_W;
	localparam int N_CH   = cnn_num_pkg::N_CH;
	localparam int N_PIX  = cnn_num_pkg::IMG_SIZE * cnn_num_pkg::IMG_SIZE;
	localparam int N_WGT  = cnn_num_pkg::N_KERNELS * cnn_num_pkg::K_SIZE * cnn_num_pkg::K_SIZE;
	localparam int N_OUT  = cnn_num_pkg::OUT_SIZE * cnn_num_pkg::OUT_SIZE;
	// opt, image beats, kernel beats, expected stream
	localparam int LINE_LEN = 1 + N_CH * N_PIX + N_CH * N_WGT + N_OUT;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              in_valid_o;
	logic [1:0]        opt;
	logic              in_valid_i;
	logic [DATA_W-1:0] image1, image2, image3;
	logic              in_valid_k;
	logic [DATA_W-1:0] kernel1, kernel2, kernel3;
	logic              out_valid;
	logic [ACC_W-1:0]  out;

	int          seed = 32'h6c65;
	int          n_tests = 0;
	logic [63:0] vals [$];

	cnn_top #(.DATA_W(DATA_W), .ACC_W(ACC_W)) dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid_o (in_valid_o),
		.opt        (opt),
		.in_valid_i (in_valid_i),
		.image1     (image1),
		.image2     (image2),
		.image3     (image3),
		.in_valid_k (in_valid_k),
		.kernel1    (kernel1),
		.kernel2    (kernel2),
		.kernel3    (kernel3),
		.out_valid  (out_valid),
		.out        (out)
	);

	always #10 clk = ~clk;

	// --------------------------------------------------------------------------
	// checks
	// --------------------------------------------------------------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_sample(input logic [ACC_W-1:0] got, input logic [ACC_W-1:0] expected);
		if (got !== expected)
			stop_on_error($sformatf("[ERROR] %0d ns out: got %h expected %h",
				$time, got, expected));
	endtask

	task automatic check_beats(input int beats);
		if (beats != N_OUT)
			stop_on_error($sformatf("[ERROR] %0d ns out_valid beats: got %0d expected %0d",
				$time, beats, N_OUT));
	endtask

	// --------------------------------------------------------------------------
	// stimulus
	// --------------------------------------------------------------------------
	task automatic load_tests();
		int          fd;
		logic [63:0] v;
		fd = $fopen("testbench/cnn_tests.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open testbench/cnn_tests.txt");
		while ($fscanf(fd, "%h", v) == 1)
			vals.push_back(v);
		$fclose(fd);
		if (vals.size() == 0 || vals.size() % LINE_LEN != 0)
			stop_on_error($sformatf("test file holds %0d values, not a whole number of tests",
				vals.size()));
		n_tests = vals.size() / LINE_LEN;
	endtask

	// 0..3 idle cycles between beats
	task automatic idle_gap();
		int gap;
		gap = int'($unsigned($random(seed)) % 4);
		repeat (gap) @(negedge clk);
	endtask

	task automatic run_job(input int base);
		int idx;
		in_valid_o = 1'b1;
		opt = 2'(vals[base]);
		@(negedge clk);
		in_valid_o = 1'b0;
		idle_gap();
		for (int p = 0; p < N_PIX; p++)
		begin
			idx = base + 1 + N_CH * p;
			in_valid_i = 1'b1;
			image1 = DATA_W'(vals[idx]);
			image2 = DATA_W'(vals[idx + 1]);
			image3 = DATA_W'(vals[idx + 2]);
			@(negedge clk);
			in_valid_i = 1'b0;
			idle_gap();
		end
		for (int w = 0; w < N_WGT; w++)
		begin
			idx = base + 1 + N_CH * N_PIX + N_CH * w;
			in_valid_k = 1'b1;
			kernel1 = DATA_W'(vals[idx]);
			kernel2 = DATA_W'(vals[idx + 1]);
			kernel3 = DATA_W'(vals[idx + 2]);
			@(negedge clk);
			in_valid_k = 1'b0;
			idle_gap();
		end
	endtask

	task automatic collect_stream(input int base);
		int beats;
		beats = 0;
		// wait for the stream to start
		while (out_valid !== 1'b1)
			@(negedge clk);
		while (out_valid === 1'b1)
		begin
			if (beats < N_OUT)
				check_sample(out, ACC_W'(vals[base + LINE_LEN - N_OUT + beats]));
			beats++;
			@(negedge clk);
		end
		check_beats(beats);
	endtask

	// out stays zero outside the stream
	always @(negedge clk)
	begin
		if (rst_n && out_valid === 1'b0)
			check_sample(out, '0);
	end

	initial
	begin
		wait (n_tests > 0);
		repeat (n_tests * 800 + 100) @(posedge clk);
		stop_on_error("timeout: the tests did not finish in the expected time");
	end

	// --------------------------------------------------------------------------
	// main sequence
	// --------------------------------------------------------------------------
	initial
	begin
		rst_n      = 1'b0;
		in_valid_o = 1'b0;
		opt        = '0;
		in_valid_i = 1'b0;
		image1     = '0;
		image2     = '0;
		image3     = '0;
		in_valid_k = 1'b0;
		kernel1    = '0;
		kernel2    = '0;
		kernel3    = '0;
		load_tests();
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		if (out_valid !== 1'b0)
			stop_on_error("out_valid is high right after reset");
		for (int t = 0; t < n_tests; t++)
		begin
			run_job(t * LINE_LEN);
			collect_stream(t * LINE_LEN);
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* testbench/cnn_tests.txt */
0  1 2 0  2 2 1  3 2 2  4 2 3  5 2 ffff  6 2 0  7 2 1  8 2 2  9 2 fffe  a 2 ffff  b 2 0  c 2 1  d 2 fffd  e 2 fffe  f 2 ffff  10 2 0   0 0 0  0 0 0  0 0 0  0 0 0  1 0 0  0 0 0  0 0 0  0 0 0  0 0 0   ffff 0 0  0 0 0  0 0 0  0 0 0  0 3 0  0 0 0  0 0 0  0 0 0  0 0 0   0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 2   0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0   1 5 2 5 3 4 4 3  0 12 2 12 4 12 4 12  5 5 6 5 7 4 8 3  0 12 0 12 2 12 2 12  9 1 a 1 b 0 c 0  0 12 0 12 0 12 0 12  d 0 e 0 f 0 10 0  0 12 0 12 0 12 0 12
2  1 2 0  2 2 1  3 2 2  4 2 3  5 2 ffff  6 2 0  7 2 1  8 2 2  9 2 fffe  a 2 ffff  b 2 0  c 2 1  d 2 fffd  e 2 fffe  f 2 ffff  10 2 0   0 0 0  0 0 0  0 0 0  0 0 0  1 0 0  0 0 0  0 0 0  0 0 0  0 0 0   ffff 0 0  0 0 0  0 0 0  0 0 0  0 3 0  0 0 0  0 0 0  0 0 0  0 0 0   0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 2   0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0   1 6 2 6 3 6 4 6  0 8 2 c 4 c 0 8  5 6 6 5 7 4 8 3  0 c 0 12 2 12 0 c  9 6 a 1 b 0 c 0  0 c 0 12 0 12 0 c  d 6 e 0 f 0 10 0  0 8 0 c 0 c 0 8
1  1 2 0  2 2 1  3 2 2  4 2 3  5 2 ffff  6 2 0  7 2 1  8 2 2  9 2 fffe  a 2 ffff  b 2 0  c 2 1  d 2 fffd  e 2 fffe  f 2 ffff  10 2 0   0 0 0  0 0 0  0 0 0  0 0 0  1 0 0  0 0 0  0 0 0  0 0 0  0 0 0   fffb 0 0  0 0 0  0 0 0  0 0 0  0 3 0  0 0 0  0 0 0  0 0 0  0 0 0   0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 7   0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0   1 1 2 1 3 fffffffff 4 ffffffffe  0 12 7 12 e 12 e 12  5 1 6 1 7 fffffffff 8 ffffffffe  fffffffff 12 0 12 7 12 7 12  9 ffffffffd a ffffffffd b ffffffffd c ffffffffc  ffffffffe 12 fffffffff 12 0 12 0 12  d ffffffffb e ffffffffb f ffffffffa 10 ffffffff9  ffffffffe 12 fffffffff 12 0 12 0 12
0  1 2 0  2 2 1  3 2 2  4 2 3  5 2 ffff  6 2 0  7 2 1  8 2 2  9 2 fffe  a 2 ffff  b 2 0  c 2 1  d 2 fffd  e 2 fffe  f 2 ffff  10 2 0   0 0 0  0 0 0  0 0 0  0 0 0  1 0 0  0 0 0  0 0 0  0 0 0  0 0 0   ffff 0 0  0 0 0  0 0 0  0 0 0  0 3 0  0 0 0  0 0 0  0 0 0  0 0 0   0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 0  0 0 2   0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0  0 1 0   1 5 2 5 3 4 4 3  0 12 2 12 4 12 4 12  5 5 6 5 7 4 8 3  0 12 0 12 2 12 2 12  9 1 a 1 b 0 c 0  0 12 0 12 0 12 0 12  d 0 e 0 f 0 10 0  0 12 0 12 0 12 0 12

/* cnn_layer.f */
hdl/cnn_num_pkg.sv
hdl/cnn_mode_pkg.sv
hdl/operand_if.sv
hdl/result_if.sv
hdl/input_loader.sv
hdl/conv_engine.sv
hdl/output_shuffle.sv
hdl/cnn_top.sv
testbench/cnn_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cnn_tb
FILELIST  ?= cnn_layer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
